// ==== cis_capture_top.f ====
+incdir+.
cis_capture_pkg.sv
pixel_packer.sv
beat_fifo.sv
csr_axil.sv
sdram_dma_writer.sv
cis_capture_top.sv
tb_cis_capture_top.sv

// ==== Makefile ====
TOP := tb_cis_capture_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f cis_capture_top.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	verilator --lint-only -Wall --timing --top-module cis_capture_top -f cis_capture_top.f

clean:
	rm -rf obj_dir

// ==== tb_cis_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cis_capture_defines.svh"

module tb_cis_capture_top;

    import cis_capture_pkg::*;

    localparam int AXI_TIMEOUT   = 50;      // cycles per handshake
    localparam int DRAIN_TIMEOUT = 4000;    // cycles for the ring writes to catch up
    localparam int SPB           = `SAMPLES_PER_BEAT;

    logic                           w_bus_clk;
    logic                           w_adc_rst;
    sample_t                        adc_data;
    logic                           adc_valid;
    logic [`AXIL_ADDR_WIDTH-1:0]    awaddr;
    logic                           awvalid;
    logic                           awready;
    logic [`AXIL_DATA_WIDTH-1:0]    wdata;
    logic [3:0]                     wstrb;
    logic                           wvalid;
    logic                           wready;
    axil_resp_t                     bresp;
    logic                           bvalid;
    logic                           bready;
    logic [`AXIL_ADDR_WIDTH-1:0]    araddr;
    logic                           arvalid;
    logic                           arready;
    logic [`AXIL_DATA_WIDTH-1:0]    rdata;
    axil_resp_t                     rresp;
    logic                           rvalid;
    logic                           rready;
    logic                           mem_write;
    mem_addr_t                      mem_address;
    beat_t                          mem_writedata;
    logic                           mem_waitrequest;

    logic [31:0]    stim_seed = 32'hf08ffc5c;
    logic [31:0]    mem_seed  = 32'hf08ffc5c;     // separate stream for the memory side
    beat_t          exp_q [$];                      // beats not yet seen on the memory port
    beat_t          mem_model [mem_addr_t];
    mem_addr_t      ring_start;
    int             ring_size;
    int             ring_idx;
    int             done_model;
    sample_t        pat_model;                      // mirrors the test pattern counter
    logic           test_mode_m;
    int             wait_pct;                       // waitrequest chance in percent
    int             keep_limit;                     // beats that fit before drops start
    int             check_cnt;
    int             err_cnt;
    int             write_cnt;

    cis_capture_top uut
    (
        .*
    );

    initial
    begin
        w_bus_clk = 1'b0;
        forever #4 w_bus_clk = ~w_bus_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    task automatic compare_hex(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d checks, %0d errors, %0d memory writes",
                 check_cnt, err_cnt, write_cnt);
    endtask

    task automatic abort_on_timeout(input string what);
        err_cnt++;
        $display("timeout while waiting for %s", what);
        print_summary();
        $display("RESULT: FAIL");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite master

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output axil_resp_t resp);
        int waited;
        waited = 0;
        @(posedge w_bus_clk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(posedge w_bus_clk);
        #1;
        while (!awready)
        begin
            waited++;
            if (waited > AXI_TIMEOUT)
                abort_on_timeout("awready");
            @(posedge w_bus_clk);
            #1;
        end
        compare_hex("wready", 128'(wready), 128'(1'b1));   // rises with awready
        @(posedge w_bus_clk);           // address and data taken here
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        while (!bvalid)
        begin
            waited++;
            if (waited > AXI_TIMEOUT)
                abort_on_timeout("bvalid");
            @(posedge w_bus_clk);
            #1;
        end
        resp = bresp;
        @(posedge w_bus_clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output axil_resp_t resp);
        int waited;
        waited = 0;
        @(posedge w_bus_clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(posedge w_bus_clk);
        #1;
        while (!arready)
        begin
            waited++;
            if (waited > AXI_TIMEOUT)
                abort_on_timeout("arready");
            @(posedge w_bus_clk);
            #1;
        end
        @(posedge w_bus_clk);           // address taken here
        #1;
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid)
        begin
            waited++;
            if (waited > AXI_TIMEOUT)
                abort_on_timeout("rvalid");
            @(posedge w_bus_clk);
            #1;
        end
        data = rdata;
        resp = rresp;
        @(posedge w_bus_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        axil_resp_t resp;
        axil_write(addr, data, resp);
        compare_hex($sformatf("bresp@%h", addr), 128'(resp), 128'(resp_okay));
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0]    data;
        axil_resp_t     resp;
        axil_read(addr, data, resp);
        compare_hex($sformatf("rdata@%h", addr), 128'(data), 128'(exp));
        compare_hex($sformatf("rresp@%h", addr), 128'(resp), 128'(resp_okay));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and reference model

    // stop dma, load a new ring, then start again from its first beat
    task automatic setup_ring(input mem_addr_t start, input int size, input logic [2:0] ctrl);
        write_reg(`REG_CTRL, 32'h0);
        write_reg(`REG_DMA_ADDR, 32'(start));
        write_reg(`REG_DMA_SIZE, 32'(size));
        ring_start  = start;
        ring_size   = size;
        ring_idx    = 0;
        test_mode_m = ctrl[2];
        write_reg(`REG_CTRL, 32'(ctrl));
    endtask

    task automatic send_beats(input int n_beats, input int valid_pct);
        logic [31:0]    r;
        sample_t        smp;
        beat_t          acc;
        int             b;
        int             s;
        @(posedge w_bus_clk);
        #1;
        for (b = 0; b < n_beats; b++)
        begin
            acc = '0;
            for (s = 0; s < SPB; s++)
            begin
                while (int'(stim_rand() % 100) >= valid_pct)
                begin
                    adc_valid = 1'b0;           // idle gap
                    @(posedge w_bus_clk);
                    #1;
                end
                r         = stim_rand();
                adc_data  = r[11:0];
                adc_valid = 1'b1;
                smp       = test_mode_m ? pat_model : r[11:0];
                acc[s*16 +: 16] = {4'h0, smp};  // first sample lowest
                pat_model = pat_model + 1'b1;
                @(posedge w_bus_clk);
                #1;
            end
            if (exp_q.size() < keep_limit)
                exp_q.push_back(acc);
        end
        adc_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            waited++;
            if (waited > DRAIN_TIMEOUT)
                abort_on_timeout("memory writes to drain");
            @(negedge w_bus_clk);
        end
    endtask

    // memory slave with random waitrequest that checks each completed write
    initial
    begin : memory_side
        beat_t      exp_beat;
        mem_addr_t  exp_addr;
        forever
        begin
            @(posedge w_bus_clk);
            #1;
            mem_seed        = lcg_next(mem_seed);
            mem_waitrequest = int'(mem_seed[31:8] % 100) < wait_pct;
            if (mem_write && !mem_waitrequest)
            begin
                write_cnt++;
                mem_model[mem_address] = mem_writedata;
                if (exp_q.size() == 0)
                begin
                    err_cnt++;
                    $display("unexpected memory write to address %h", mem_address);
                end
                else
                begin
                    exp_beat = exp_q.pop_front();
                    exp_addr = ring_start + mem_addr_t'(ring_idx * `BEAT_BYTES);
                    compare_hex("mem_address", 128'(mem_address), 128'(exp_addr));
                    if (!mem_model.exists(exp_addr))
                    begin
                        err_cnt++;
                        $display("no beat stored at expected address %h", exp_addr);
                    end
                    else
                        compare_hex("mem_writedata", mem_model[exp_addr], exp_beat);
                    ring_idx++;
                    if (ring_idx == ring_size)
                    begin
                        ring_idx = 0;           // buffer complete
                        done_model++;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial
    begin : main_seq
        logic [31:0]    r;
        logic [31:0]    data;
        axil_resp_t     resp;
        logic [7:0]     addr;
        int             i;

        w_adc_rst       = 1'b1;
        adc_data        = '0;
        adc_valid       = 1'b0;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wstrb           = 4'hf;
        wvalid          = 1'b0;
        bready          = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b0;
        mem_waitrequest = 1'b0;
        ring_start      = '0;
        ring_size       = 1;
        ring_idx        = 0;
        done_model      = 0;
        pat_model       = '0;
        test_mode_m     = 1'b0;
        wait_pct        = 0;
        keep_limit      = 1000000;
        check_cnt       = 0;
        err_cnt         = 0;
        write_cnt       = 0;

        repeat (5) @(posedge w_bus_clk);
        #1;
        w_adc_rst = 1'b0;

        // register readback and unmapped offsets
        read_reg(`REG_STATUS, 32'h0);
        read_reg(`REG_DONE_CNT, 32'h0);
        for (i = 0; i < 6; i++)
        begin
            r = stim_rand();
            write_reg(`REG_CTRL, r);
            read_reg(`REG_CTRL, r & 32'h7);
            r = stim_rand();
            write_reg(`REG_DMA_ADDR, r);
            read_reg(`REG_DMA_ADDR, r & 32'h0fff_fff0);
            r = stim_rand();
            write_reg(`REG_DMA_SIZE, r);
            read_reg(`REG_DMA_SIZE, r & 32'h0fff_ffff);
            addr = 8'h14 + 8'(4 * (stim_rand() % 50));
            axil_read(addr, data, resp);
            compare_hex("rdata unmapped", 128'(data), 128'h0);
            compare_hex("rresp unmapped", 128'(resp), 128'(resp_slverr));
            axil_write(addr, stim_rand(), resp);
            compare_hex("bresp unmapped", 128'(resp), 128'(resp_slverr));
        end
        write_reg(`REG_CTRL, 32'h0);

        // packing, ring addresses and buffer count
        for (i = 0; i < 2; i++)
        begin
            setup_ring(mem_addr_t'(stim_rand()) & ~mem_addr_t'(15),
                       1 + int'(stim_rand() % 5), 3'b011);
            send_beats(24, 60);
            wait_drain();
            read_reg(`REG_DONE_CNT, 32'(done_model % 65536));
        end

        // test pattern picks up from the samples taken so far
        write_reg(`REG_CTRL, 32'h7);
        test_mode_m = 1'b1;
        send_beats(16, 70);
        wait_drain();
        read_reg(`REG_DONE_CNT, 32'(done_model % 65536));

        // random stalls with bursts well below the drop point
        setup_ring(mem_addr_t'(stim_rand()) & ~mem_addr_t'(15),
                   1 + int'(stim_rand() % 5), 3'b011);
        wait_pct = 50;
        for (i = 0; i < 4; i++)
        begin
            send_beats(10, 80);
            wait_drain();
        end
        read_reg(`REG_STATUS, 32'h0);
        read_reg(`REG_DONE_CNT, 32'(done_model % 65536));

        // memory stalled so only FIFO plus the held beat survive
        wait_pct   = 100;
        keep_limit = `FIFO_DEPTH + 1;
        send_beats(40, 100);
        read_reg(`REG_STATUS, 32'h1);
        write_reg(`REG_STATUS, 32'h1);
        read_reg(`REG_STATUS, 32'h0);
        wait_pct = 0;
        wait_drain();
        keep_limit = 1000000;
        read_reg(`REG_DONE_CNT, 32'(done_model % 65536));

        print_summary();
        if (err_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cis_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cis_capture_defines.svh"

module cis_capture_top
(
    input  wire                             w_bus_clk,
    input  wire                             w_adc_rst,

    input  wire cis_capture_pkg::sample_t   adc_data,
    input  wire                             adc_valid,

    input  wire [`AXIL_ADDR_WIDTH-1:0]      awaddr,
    input  wire                             awvalid,
    output logic                            awready,
    input  wire [`AXIL_DATA_WIDTH-1:0]      wdata,
    input  wire [3:0]                       wstrb,
    input  wire                             wvalid,
    output logic                            wready,
    output cis_capture_pkg::axil_resp_t     bresp,
    output logic                            bvalid,
    input  wire                             bready,
    input  wire [`AXIL_ADDR_WIDTH-1:0]      araddr,
    input  wire                             arvalid,
    output logic                            arready,
    output logic [`AXIL_DATA_WIDTH-1:0]     rdata,
    output cis_capture_pkg::axil_resp_t     rresp,
    output logic                            rvalid,
    input  wire                             rready,

    output logic                            mem_write,
    output cis_capture_pkg::mem_addr_t      mem_address,
    output cis_capture_pkg::beat_t          mem_writedata,
    input  wire                             mem_waitrequest
);

    import cis_capture_pkg::*;

    beat_t          packed_beat;
    beat_t          fifo_beat;
    logic           push;
    logic           overflow;
    logic           fifo_full;
    logic           fifo_empty;
    logic           fifo_pop;
    logic           capture_en;
    logic           dma_on;
    logic           test_mode;
    mem_addr_t      dma_addr;
    beat_cnt_t      dma_size;
    done_cnt_t      done_cnt;

    //////////////////////////////////////////////////////////////////////
    // sample path

    pixel_packer pixel_packer
    (
        .w_bus_clk      ( w_bus_clk     ),
        .w_adc_rst      ( w_adc_rst     ),
        .adc_data       ( adc_data      ),
        .adc_valid      ( adc_valid     ),
        .capture_en     ( capture_en    ),
        .test_mode      ( test_mode     ),
        .fifo_full      ( fifo_full     ),
        .beat           ( packed_beat   ),
        .push           ( push          ),
        .overflow       ( overflow      )
    );

    beat_fifo beat_fifo
    (
        .w_bus_clk      ( w_bus_clk     ),
        .w_adc_rst      ( w_adc_rst     ),
        .push           ( push          ),
        .wr_data        ( packed_beat   ),
        .pop            ( fifo_pop      ),
        .rd_data        ( fifo_beat     ),
        .empty          ( fifo_empty    ),
        .full           ( fifo_full     )
    );

    //////////////////////////////////////////////////////////////////////
    // registers and dma

    csr_axil csr_axil
    (
        .w_bus_clk      ( w_bus_clk     ),
        .w_adc_rst      ( w_adc_rst     ),
        .awaddr         ( awaddr        ),
        .awvalid        ( awvalid       ),
        .awready        ( awready       ),
        .wdata          ( wdata         ),
        .wstrb          ( wstrb         ),
        .wvalid         ( wvalid        ),
        .wready         ( wready        ),
        .bresp          ( bresp         ),
        .bvalid         ( bvalid        ),
        .bready         ( bready        ),
        .araddr         ( araddr        ),
        .arvalid        ( arvalid       ),
        .arready        ( arready       ),
        .rdata          ( rdata         ),
        .rresp          ( rresp         ),
        .rvalid         ( rvalid        ),
        .rready         ( rready        ),
        .overflow       ( overflow      ),
        .done_cnt       ( done_cnt      ),
        .capture_en     ( capture_en    ),
        .dma_on         ( dma_on        ),
        .test_mode      ( test_mode     ),
        .dma_addr       ( dma_addr      ),
        .dma_size       ( dma_size      )
    );

    sdram_dma_writer sdram_dma_writer
    (
        .w_bus_clk       ( w_bus_clk        ),
        .w_adc_rst       ( w_adc_rst        ),
        .dma_on          ( dma_on           ),
        .dma_addr        ( dma_addr         ),
        .dma_size        ( dma_size         ),
        .fifo_data       ( fifo_beat        ),
        .fifo_empty      ( fifo_empty       ),
        .fifo_pop        ( fifo_pop         ),
        .done_cnt        ( done_cnt         ),
        .mem_write       ( mem_write        ),
        .mem_address     ( mem_address      ),
        .mem_writedata   ( mem_writedata    ),
        .mem_waitrequest ( mem_waitrequest  )
    );

endmodule

`default_nettype wire

// ==== sdram_dma_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cis_capture_defines.svh"

module sdram_dma_writer
(
    input  wire                             w_bus_clk,
    input  wire                             w_adc_rst,

    input  wire                             dma_on,
    input  wire cis_capture_pkg::mem_addr_t dma_addr,
    input  wire cis_capture_pkg::beat_cnt_t dma_size,

    input  wire cis_capture_pkg::beat_t     fifo_data,
    input  wire                             fifo_empty,
    output logic                            fifo_pop,

    output cis_capture_pkg::done_cnt_t      done_cnt,

    output logic                            mem_write,
    output cis_capture_pkg::mem_addr_t      mem_address,
    output cis_capture_pkg::beat_t          mem_writedata,
    input  wire                             mem_waitrequest
);

    import cis_capture_pkg::*;

    logic           dma_on_q;
    logic           restart_q;      // rise seen while a write was stalled
    logic           restart;
    logic           done_w;
    logic           slot_free;
    logic           wrap;
    beat_cnt_t      beat_idx;
    beat_cnt_t      last_idx;

    assign done_w    = mem_write && !mem_waitrequest;
    assign slot_free = !mem_write || done_w;
    assign restart   = (dma_on && !dma_on_q) || restart_q;
    assign fifo_pop  = dma_on && !fifo_empty && slot_free;

    // size zero behaves as a one beat ring
    assign last_idx  = (dma_size == '0) ? '0 : dma_size - 1'b1;
    assign wrap      = done_w && (beat_idx == last_idx);

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            dma_on_q    <= 1'b0;
            restart_q   <= 1'b0;
            mem_write   <= 1'b0;
            mem_address <= '0;
            beat_idx    <= '0;
            done_cnt    <= '0;
        end
        else
        begin
            dma_on_q  <= dma_on;
            restart_q <= restart && !slot_free;

            if (fifo_pop)
                mem_write <= 1'b1;
            else if (done_w)
                mem_write <= 1'b0;      // dma_off lands here too

            if (wrap)
                done_cnt <= done_cnt + 1'b1;

            // address only moves between writes
            if ((restart && slot_free) || wrap)
            begin
                mem_address <= dma_addr;    // back to the ring start
                beat_idx    <= '0;
            end
            else if (done_w)
            begin
                mem_address <= mem_address + mem_addr_t'(`BEAT_BYTES);
                beat_idx    <= beat_idx + 1'b1;
            end
        end
    end

    // holding register for the beat in flight
    always_ff @(posedge w_bus_clk)
    begin
        if (fifo_pop)
            mem_writedata <= fifo_data;
    end

endmodule

`default_nettype wire

// ==== csr_axil.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cis_capture_defines.svh"

module csr_axil
(
    input  wire                             w_bus_clk,
    input  wire                             w_adc_rst,

    input  wire [`AXIL_ADDR_WIDTH-1:0]      awaddr,
    input  wire                             awvalid,
    output logic                            awready,
    input  wire [`AXIL_DATA_WIDTH-1:0]      wdata,
    input  wire [3:0]                       wstrb,
    input  wire                             wvalid,
    output logic                            wready,
    output cis_capture_pkg::axil_resp_t     bresp,
    output logic                            bvalid,
    input  wire                             bready,

    input  wire [`AXIL_ADDR_WIDTH-1:0]      araddr,
    input  wire                             arvalid,
    output logic                            arready,
    output logic [`AXIL_DATA_WIDTH-1:0]     rdata,
    output cis_capture_pkg::axil_resp_t     rresp,
    output logic                            rvalid,
    input  wire                             rready,

    input  wire                             overflow,
    input  wire cis_capture_pkg::done_cnt_t done_cnt,

    output logic                            capture_en,
    output logic                            dma_on,
    output logic                            test_mode,
    output cis_capture_pkg::mem_addr_t      dma_addr,
    output cis_capture_pkg::beat_cnt_t      dma_size
);

    import cis_capture_pkg::*;

    localparam int AW = `AXIL_ADDR_WIDTH;
    localparam int DW = `AXIL_DATA_WIDTH;

    logic               ovf_flag;       // sticky, w1c
    logic [DW-1:0]      rd_mux;

    function automatic logic is_mapped(input logic [AW-1:0] addr);
        return (addr == `REG_CTRL)     || (addr == `REG_STATUS)   ||
               (addr == `REG_DMA_ADDR) || (addr == `REG_DMA_SIZE) ||
               (addr == `REG_DONE_CNT);
    endfunction

    always_comb
    begin
        case (araddr)
            `REG_CTRL:     rd_mux = DW'({test_mode, dma_on, capture_en});
            `REG_STATUS:   rd_mux = DW'(ovf_flag);
            `REG_DMA_ADDR: rd_mux = DW'(dma_addr);
            `REG_DMA_SIZE: rd_mux = DW'(dma_size);
            `REG_DONE_CNT: rd_mux = DW'(done_cnt);
            default:       rd_mux = '0;     // unmapped reads as zero
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // write channel, handshake cycle is the one with awready high

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            bresp      <= resp_okay;
            capture_en <= 1'b0;
            dma_on     <= 1'b0;
            test_mode  <= 1'b0;
            dma_addr   <= '0;
            dma_size   <= '0;
            ovf_flag   <= 1'b0;
        end
        else
        begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;

            if (bvalid && bready)
                bvalid <= 1'b0;

            if (awready)
            begin
                bvalid <= 1'b1;
                bresp  <= is_mapped(awaddr) ? resp_okay : resp_slverr;
                case (awaddr)
                    `REG_CTRL:     {test_mode, dma_on, capture_en} <= wdata[2:0];
                    `REG_DMA_ADDR: dma_addr <= wdata[`MEM_ADDR_WIDTH-1:0] &
                                               ~mem_addr_t'(`BEAT_BYTES - 1);
                    `REG_DMA_SIZE: dma_size <= wdata[`MEM_ADDR_WIDTH-1:0];
                    default:       ;        // done_cnt is read only
                endcase
            end

            // a new overflow beats a clear in the same cycle
            if (overflow)
                ovf_flag <= 1'b1;
            else if (awready && (awaddr == `REG_STATUS) && wdata[0])
                ovf_flag <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read channel

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= resp_okay;
        end
        else
        begin
            arready <= arvalid && !rvalid && !arready;

            if (rvalid && rready)
                rvalid <= 1'b0;

            if (arready)
            begin
                rvalid <= 1'b1;
                rdata  <= rd_mux;
                rresp  <= is_mapped(araddr) ? resp_okay : resp_slverr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== beat_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cis_capture_defines.svh"

module beat_fifo
(
    input  wire                         w_bus_clk,
    input  wire                         w_adc_rst,

    input  wire                         push,
    input  wire cis_capture_pkg::beat_t wr_data,
    input  wire                         pop,

    output cis_capture_pkg::beat_t      rd_data,
    output logic                        empty,
    output logic                        full
);

    import cis_capture_pkg::*;

    localparam int AW = $clog2(`FIFO_DEPTH);

    beat_t              mem [`FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [AW:0]        count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty   = (count == '0);
    assign full    = (count == (AW+1)'(`FIFO_DEPTH));
    assign rd_data = mem[rd_ptr];           // show-ahead

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // power of two depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge w_bus_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

// ==== pixel_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cis_capture_defines.svh"

module pixel_packer
(
    input  wire                         w_bus_clk,
    input  wire                         w_adc_rst,

    input  wire cis_capture_pkg::sample_t adc_data,
    input  wire                         adc_valid,

    input  wire                         capture_en,
    input  wire                         test_mode,

    input  wire                         fifo_full,

    output cis_capture_pkg::beat_t      beat,
    output logic                        push,
    output logic                        overflow
);

    import cis_capture_pkg::*;

    localparam int SLOT  = `SAMPLE_SLOT;
    localparam int IDX_W = $clog2(`SAMPLES_PER_BEAT);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(`SAMPLES_PER_BEAT - 1);

    logic                           take;
    sample_t                        pat_cnt;
    sample_t                        sample_sel;
    logic [SLOT-1:0]                slot_val;
    logic [IDX_W-1:0]               slot_idx;
    logic [`BEAT_WIDTH-SLOT-1:0]    acc;        // first seven slots of a beat

    assign take       = adc_valid && capture_en;
    assign sample_sel = test_mode ? pat_cnt : adc_data;
    assign slot_val   = SLOT'(sample_sel);      // zero extend into slot

    // fifo drops the beat, flag it for the status register
    assign overflow   = push && fifo_full;

    always_ff @(posedge w_bus_clk)
    begin
        if (w_adc_rst)
        begin
            slot_idx <= '0;
            pat_cnt  <= '0;
            push     <= 1'b0;
        end
        else
        begin
            push <= take && (slot_idx == LAST);

            if (take)
                pat_cnt <= pat_cnt + 1'b1;      // runs in both modes

            if (!capture_en)
                slot_idx <= '0;                 // partial beat discarded
            else if (take)
                slot_idx <= slot_idx + 1'b1;    // wraps after eighth slot
        end
    end

    //////////////////////////////////////////////////////////////////////
    // beat assembly, slot 0 in the low bits

    always_ff @(posedge w_bus_clk)
    begin
        if (take)
        begin
            if (slot_idx == LAST)
                beat <= {slot_val, acc};
            else
                acc[slot_idx*SLOT +: SLOT] <= slot_val;
        end
    end

endmodule

`default_nettype wire

// ==== cis_capture_pkg.sv ====
`default_nettype none

package cis_capture_pkg;

    `include "cis_capture_defines.svh"

    typedef logic [`ADC_WIDTH-1:0]      sample_t;
    typedef logic [`BEAT_WIDTH-1:0]     beat_t;
    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`MEM_ADDR_WIDTH-1:0] beat_cnt_t;     // buffer size in beats
    typedef logic [15:0]                done_cnt_t;

    // only the two responses this slave ever returns
    typedef enum logic [1:0]
    {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_t;

endpackage

`default_nettype wire

// ==== cis_capture_defines.svh ====
`ifndef CIS_CAPTURE_DEFINES_SVH
`define CIS_CAPTURE_DEFINES_SVH

// sample path geometry
`define ADC_WIDTH           12
`define SAMPLE_SLOT         16
`define SAMPLES_PER_BEAT    8
`define BEAT_WIDTH          128
`define BEAT_BYTES          16

`define MEM_ADDR_WIDTH      28      // byte address into sdram
`define FIFO_DEPTH          16      // beats

// register port
`define AXIL_ADDR_WIDTH     8
`define AXIL_DATA_WIDTH     32

`define REG_CTRL            8'h00
`define REG_STATUS          8'h04
`define REG_DMA_ADDR        8'h08
`define REG_DMA_SIZE        8'h0C
`define REG_DONE_CNT        8'h10

`endif
